// ==== transferAck.f ====
+incdir+rtl
rtl/busCyclePkg.sv
rtl/termPkg.sv
rtl/cycleDecode.sv
rtl/termTimers.sv
rtl/ackDriver.sv
rtl/transferAck.sv
tests/transferAckTb.sv

// ==== Makefile ====
# Verilator build and run of the transfer acknowledge testbench

VERILATOR ?= verilator
TOP       ?= transferAckTb
FILELIST  ?= transferAck.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM = $(BUILD_DIR)/V$(TOP)
SRCS = $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/transferAckTb.sv ====
// One cycle in flight at a time; ciaClk moves in step with CLK40, so only CIA acks are checked in a window
`timescale 1ns/10ps
`include "transferAck_cfg.svh"

module transferAckTb
    import busCyclePkg::*;
();

    localparam int NUM_TESTS = 40;
    // Worst cycle is the watchdog plus the pulse and idle gaps
    localparam int CYCLE_LIMIT = NUM_TESTS * (`WATCHDOG_CYCLES + 20);

    logic      CLK40;
    logic      DELAYED_TACK_RST;
    logic      tsN;
    logic      romSel, rtcSel, ciaSel, agnusSpace, autoVector;
    logic      acTack;
    logic      ciaClk;
    romDelay_t romDelay;
    logic      tackN, tbiN, tciN, ackOe, romEnN;

    int   cyc = 0;
    int   errors = 0;
    int   checks = 0;
    int   acksSeen = 0;
    int   ciaPeriod = 20;
    int   romFrom = 0;
    int   romTo = 0;
    int   pulsePhase = 0;
    // Expected acknowledge, one entry per started cycle
    int   qLo[$];
    int   qHi[$];
    logic qTci[$];

    transferAck u_transferAck (.*);

    //////////////////////////////////////////////////////////////////////
    // Clock, cycle count, CIA clock
    //////////////////////////////////////////////////////////////////////

    initial begin
        CLK40 = 1'b0;
        forever #2 CLK40 = ~CLK40;
    end

    always @(posedge CLK40) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles", cyc);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // High for the first half of each period, counted in CLK40 edges
    function automatic logic ciaLevel(input int k, input int p);
        return (k % p) < (p / 2);
    endfunction

    always @(posedge CLK40) begin
        #1;
        ciaClk = ciaLevel(cyc, ciaPeriod);
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and check
    //////////////////////////////////////////////////////////////////////

    // N is the edge where tsN is sampled low; lo and hi are the edges where tackN falls
    function automatic void expectAck(input cycleKind_t kind, input romDelay_t code,
                                      input int n, input int tackDelay, input int period,
                                      output int lo, output int hi, output logic tci,
                                      output int romLo, output int romHi);
        int d;
        int f;
        d = 0;
        tci = 1'b0;
        romLo = 0;
        romHi = 0;
        case (kind)
            kindRom: begin
                case (code)
                    2'd0: d = `ROM_DELAY_0;
                    2'd1: d = `ROM_DELAY_1;
                    2'd2: d = `ROM_DELAY_2;
                    default: d = `ROM_DELAY_3;
                endcase
                // Cacheable, and ROM enabled until termDone plus two
                tci = 1'b1;
                romLo = n + 2;
                romHi = n + 3 + d;
            end
            kindRtc: d = `RTC_WAIT_CYCLES;
            kindAutoVec: d = 1;
            // acTack seen at N plus tackDelay, ack on the next edge
            kindOther: d = (tackDelay > 0) ? tackDelay - 1 : `WATCHDOG_CYCLES;
            default: d = 0;
        endcase
        lo = n + 2 + d;
        hi = lo;
        if (kind == kindCia) begin
            // First falling edge after a high sample at or after N
            f = n + 1;
            while (!(ciaLevel(f - 1, period) && !ciaLevel(f, period))) begin
                f++;
            end
            lo = f + 3;
            hi = f + 5;
        end
        if (kind == kindAgnus) begin
            lo = -1;
            hi = -1;
        end
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Pin comparison, sampled mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge CLK40) begin : compare
        int   lo;
        int   hi;
        logic tci;
        if (!DELAYED_TACK_RST) begin
            checkValue("romEnN", 32'(romEnN), 32'(!(cyc >= romFrom && cyc < romTo)));
            case (pulsePhase)
                0: begin
                    if (!tackN) begin
                        if (qLo.size() == 0) begin
                            errors++;
                            $display("Acknowledge at cycle %0d with no cycle started", cyc);
                        end else begin
                            lo = qLo.pop_front();
                            hi = qHi.pop_front();
                            tci = qTci.pop_front();
                            if (lo == hi) begin
                                checkValue("tackN fall cycle", cyc, lo);
                            end else begin
                                checkValue("tackN fall in CIA window",
                                           32'(cyc >= lo && cyc <= hi), 32'd1);
                            end
                            checkValue("tciN", 32'(tciN), 32'(tci));
                        end
                        checkValue("tbiN", 32'(tbiN), 32'd0);
                        checkValue("ackOe", 32'(ackOe), 32'd1);
                        pulsePhase = 1;
                    end else begin
                        // Outside the pulse the pins stay released
                        checkValue("ackOe", 32'(ackOe), 32'd0);
                    end
                end
                1: begin
                    // Driven high for one cycle before release
                    checkValue("tackN", 32'(tackN), 32'd1);
                    checkValue("tbiN", 32'(tbiN), 32'd1);
                    checkValue("tciN", 32'(tciN), 32'd1);
                    checkValue("ackOe", 32'(ackOe), 32'd1);
                    pulsePhase = 2;
                end
                default: begin
                    checkValue("ackOe", 32'(ackOe), 32'd0);
                    checkValue("tackN", 32'(tackN), 32'd1);
                    acksSeen++;
                    pulsePhase = 0;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // tsLen above one repeats tsN while busy, tackDelay of zero lets the watchdog fire
    task automatic runCycle(input cycleKind_t kind, input romDelay_t code, input int tsLen,
                            input int tackDelay, input int period);
        int   n;
        int   lo;
        int   hi;
        int   romLo;
        int   romHi;
        int   seen;
        logic tci;
        @(negedge CLK40);
        ciaPeriod = period;
        @(posedge CLK40);
        #1;
        n = cyc + 1;
        seen = acksSeen;
        // Lower-priority selects ride along to exercise the decode order
        agnusSpace = (kind == kindAgnus);
        autoVector = (kind == kindAgnus) || (kind == kindAutoVec);
        romSel = kind inside {kindAgnus, kindAutoVec, kindRom};
        rtcSel = (kind == kindRom) || (kind == kindRtc);
        ciaSel = kind inside {kindRom, kindRtc, kindCia};
        romDelay = code;
        tsN = 1'b0;
        expectAck(kind, code, n, tackDelay, period, lo, hi, tci, romLo, romHi);
        romFrom = romLo;
        romTo = romHi;
        if (lo >= 0) begin
            qLo.push_back(lo);
            qHi.push_back(hi);
            qTci.push_back(tci);
        end
        repeat (tsLen) @(posedge CLK40);
        #1;
        tsN = 1'b1;
        {agnusSpace, autoVector, romSel, rtcSel, ciaSel} = 5'b0;
        if (kind == kindOther && tackDelay > 0) begin
            while (cyc < n + tackDelay - 1) begin
                @(posedge CLK40);
                #1;
            end
            acTack = 1'b1;
            @(posedge CLK40);
            #1;
            acTack = 1'b0;
        end
        // Wait for release, Agnus gets a quiet stretch instead
        if (lo >= 0) begin
            while (acksSeen == seen) @(posedge CLK40);
        end else begin
            repeat (8) @(posedge CLK40);
        end
        repeat ($urandom_range(1, 3)) @(posedge CLK40);
    endtask

    initial begin
        DELAYED_TACK_RST = 1'b1;
        tsN = 1'b1;
        {agnusSpace, autoVector, romSel, rtcSel, ciaSel} = 5'b0;
        acTack = 1'b0;
        ciaClk = 1'b0;
        romDelay = 2'd0;
        void'($urandom(32'h3d8b));
        repeat (3) @(posedge CLK40);
        #1;
        // Everything inactive while in reset
        checkValue("tackN", 32'(tackN), 32'd1);
        checkValue("tbiN", 32'(tbiN), 32'd1);
        checkValue("tciN", 32'(tciN), 32'd1);
        checkValue("romEnN", 32'(romEnN), 32'd1);
        checkValue("ackOe", 32'(ackOe), 32'd0);
        DELAYED_TACK_RST = 1'b0;
        // Directed pass over every kind and jumper code
        runCycle(kindRom, 2'd0, 1, 0, 20);
        runCycle(kindRom, 2'd1, 1, 0, 20);
        runCycle(kindRom, 2'd2, 1, 0, 20);
        runCycle(kindRom, 2'd3, 3, 0, 20);
        runCycle(kindAutoVec, 2'd0, 1, 0, 20);
        runCycle(kindRtc, 2'd0, 2, 0, 20);
        runCycle(kindCia, 2'd0, 1, 0, 26);
        runCycle(kindOther, 2'd0, 1, 10, 20);
        runCycle(kindOther, 2'd0, 1, 0, 20);
        runCycle(kindAgnus, 2'd0, 1, 0, 20);
        for (int i = 10; i < NUM_TESTS; i++) begin
            runCycle(cycleKind_t'($urandom_range(0, 5)), romDelay_t'($urandom_range(0, 3)),
                     $urandom_range(1, 3),
                     ($urandom_range(0, 3) == 0) ? 0 : $urandom_range(4, 100),
                     $urandom_range(20, 40));
        end
        repeat (4) @(posedge CLK40);
        if (qLo.size() != 0) begin
            errors++;
            $display("No acknowledge for %0d started cycles", qLo.size());
        end
        $display("Run complete: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/transferAck.sv ====
// CLK40 domain only; tri-state buffers for tackN, tbiN and tciN sit at board level
`timescale 1ns/10ps

module transferAck (
    input  logic                  CLK40,
    input  logic                  DELAYED_TACK_RST,
    input  logic                  tsN,
    input  logic                  romSel,
    input  logic                  rtcSel,
    input  logic                  ciaSel,
    input  logic                  agnusSpace,
    input  logic                  autoVector,
    input  logic                  acTack,
    input  logic                  ciaClk,
    input  busCyclePkg::romDelay_t romDelay,
    output logic                  tackN,
    output logic                  tbiN,
    output logic                  tciN,
    output logic                  ackOe,
    output logic                  romEnN
);

    // Stage strobes
    logic                   cycleStart;
    busCyclePkg::cycleKind_t cycleKind;
    logic                   termDone;
    logic                   termCacheable;
    logic                   ackEnd;

    // Decode
    cycleDecode u_cycleDecode (
        .CLK40(CLK40), .DELAYED_TACK_RST(DELAYED_TACK_RST), .tsN(tsN),
        .romSel(romSel), .rtcSel(rtcSel), .ciaSel(ciaSel), .agnusSpace(agnusSpace),
        .autoVector(autoVector), .ackEnd(ackEnd), .cycleStart(cycleStart),
        .cycleKind(cycleKind)
    );

    // Execute
    termTimers u_termTimers (
        .CLK40(CLK40), .DELAYED_TACK_RST(DELAYED_TACK_RST), .cycleStart(cycleStart),
        .cycleKind(cycleKind), .romDelay(romDelay), .acTack(acTack), .ciaClk(ciaClk),
        .termDone(termDone), .termCacheable(termCacheable), .romEnN(romEnN)
    );

    // Result
    ackDriver u_ackDriver (
        .CLK40(CLK40), .DELAYED_TACK_RST(DELAYED_TACK_RST), .termDone(termDone),
        .termCacheable(termCacheable), .tackN(tackN), .tbiN(tbiN), .tciN(tciN),
        .ackOe(ackOe), .ackEnd(ackEnd)
    );

endmodule

// ==== rtl/ackDriver.sv ====
// Drives values and enable only; the board buffer makes the tri-state pins from ackOe
`timescale 1ns/10ps

module ackDriver
    import termPkg::*;
(
    input  logic CLK40,
    input  logic DELAYED_TACK_RST,
    input  logic termDone,
    input  logic termCacheable,
    output logic tackN,
    output logic tbiN,
    output logic tciN,
    output logic ackOe,
    output logic ackEnd
);

    ackState_t ackState;

    //////////////////////////////////////////////////////////////////////
    // Acknowledge pulse
    //////////////////////////////////////////////////////////////////////

    // Low one cycle, driven high one cycle, then released
    // Driving high first keeps the bus from floating low on release
    always_ff @(posedge CLK40 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            ackState <= ackIdle;
            tackN    <= 1'b1;
            tbiN     <= 1'b1;
            tciN     <= 1'b1;
            ackOe    <= 1'b0;
            ackEnd   <= 1'b0;
        end else begin
            ackEnd <= 1'b0;
            case (ackState)
                ackIdle: begin
                    if (termDone) begin
                        ackOe    <= 1'b1;
                        tackN    <= 1'b0;
                        // No bursts from this device
                        tbiN     <= 1'b0;
                        // ROM may be cached, everything else inhibits
                        tciN     <= termCacheable;
                        ackState <= ackLow;
                    end
                end
                ackLow: begin
                    tackN    <= 1'b1;
                    tbiN     <= 1'b1;
                    tciN     <= 1'b1;
                    ackState <= ackHigh;
                end
                ackHigh: begin
                    // Release the pins and free decode
                    ackOe    <= 1'b0;
                    ackEnd   <= 1'b1;
                    ackState <= ackIdle;
                end
                default: ackState <= ackIdle;
            endcase
        end
    end

    // Pulse shape on the pins, low only while driven
    assert property (@(posedge CLK40) disable iff (DELAYED_TACK_RST)
        !tackN |-> ackOe ##1 (tackN && ackOe) ##1 (!ackOe && ackEnd))
        else $error("tackN pulse shape or output enable broken");

endmodule

// ==== rtl/termTimers.sv ====
// CLK40 only; ciaClk is asynchronous and synchronized here, acTack must be glitch free
`timescale 1ns/10ps
`include "transferAck_cfg.svh"

module termTimers
    import busCyclePkg::*;
    import termPkg::*;
(
    input  logic       CLK40,
    input  logic       DELAYED_TACK_RST,
    input  logic       cycleStart,
    input  cycleKind_t cycleKind,
    input  romDelay_t  romDelay,
    input  logic       acTack,
    input  logic       ciaClk,
    output logic       termDone,
    output logic       termCacheable,
    output logic       romEnN
);

    termState_t termState;
    termCount_t termCnt;
    termCount_t startDelay;
    logic [1:0] ciaSync;
    logic       endOther;
    logic       finish;

    //////////////////////////////////////////////////////////////////////
    // Delay lookup
    //////////////////////////////////////////////////////////////////////

    // Cycles from cycleStart to termDone
    // CIA cycles do not use it, Other uses it as the watchdog
    function automatic termCount_t delayFor(input cycleKind_t kind, input romDelay_t code);
        termCount_t d;
        case (kind)
            kindRom: begin
                case (code)
                    2'd0: d = termCount_t'(`ROM_DELAY_0);
                    2'd1: d = termCount_t'(`ROM_DELAY_1);
                    2'd2: d = termCount_t'(`ROM_DELAY_2);
                    default: d = termCount_t'(`ROM_DELAY_3);
                endcase
            end
            kindRtc: d = termCount_t'(`RTC_WAIT_CYCLES);
            // No data moves on an autovector, shortest possible
            kindAutoVec: d = termCount_t'(1);
            default: d = termCount_t'(`WATCHDOG_CYCLES);
        endcase
        return d;
    endfunction

    assign startDelay = delayFor(cycleKind, romDelay);

    // External slave claimed the cycle
    assign endOther = (cycleKind == kindOther) && acTack;

    //////////////////////////////////////////////////////////////////////
    // CIA clock synchronizer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            ciaSync <= 2'b00;
        end else begin
            ciaSync <= {ciaSync[0], ciaClk};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Termination FSM
    //////////////////////////////////////////////////////////////////////

    // End of cycle this edge
    // D of 1 ends straight from idle
    always_comb begin
        case (termState)
            termIdle: begin
                finish = cycleStart && (cycleKind != kindCia)
                    && (startDelay == termCount_t'(1));
            end
            termWait:   finish = endOther || (termCnt == '0);
            termCiaLow: finish = !ciaSync[1];
            default:    finish = 1'b0;
        endcase
    end

    always_ff @(posedge CLK40 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            termState     <= termIdle;
            termCnt       <= '0;
            termDone      <= 1'b0;
            termCacheable <= 1'b0;
            romEnN        <= 1'b1;
        end else begin
            termDone      <= finish;
            termCacheable <= finish && (cycleKind == kindRom);
            if (finish) begin
                // Hold counts two cycles for the ROM enable
                termCnt   <= '0;
                termState <= termHold;
            end else begin
                case (termState)
                    termIdle: begin
                        if (cycleStart && cycleKind == kindCia) begin
                            termState <= termCiaHigh;
                        end else if (cycleStart) begin
                            // Wait already spent one cycle when the count runs out
                            termCnt   <= startDelay - termCount_t'(2);
                            termState <= termWait;
                        end
                    end
                    termWait: termCnt <= termCnt - termCount_t'(1);
                    // Need a high phase after start, then its falling edge
                    termCiaHigh: begin
                        if (ciaSync[1]) begin
                            termState <= termCiaLow;
                        end
                    end
                    // Stay until the low sample ends the cycle
                    termCiaLow: termState <= termCiaLow;
                    termHold: begin
                        if (termCnt == termCount_t'(1)) begin
                            romEnN    <= 1'b1;
                            termState <= termIdle;
                        end else begin
                            termCnt <= termCnt + termCount_t'(1);
                        end
                    end
                    default: termState <= termIdle;
                endcase
            end
            // ROM enable from the first cycle the stage sees
            if (termState == termIdle && cycleStart && cycleKind == kindRom) begin
                romEnN <= 1'b0;
            end
        end
    end

    // Single-cycle strobe, only inside a started cycle
    assert property (@(posedge CLK40) disable iff (DELAYED_TACK_RST)
        termDone |-> ($past(cycleStart) || $past(termState) != termIdle) ##1 !termDone)
        else $error("termDone outside a started cycle or longer than one cycle");

endmodule

// ==== rtl/cycleDecode.sv ====
// One cycle in flight only; tsN seen while busy is dropped, select inputs must be valid with tsN
`timescale 1ns/10ps

module cycleDecode
    import busCyclePkg::*;
(
    input  logic       CLK40,
    input  logic       DELAYED_TACK_RST,
    input  logic       tsN,
    input  logic       romSel,
    input  logic       rtcSel,
    input  logic       ciaSel,
    input  logic       agnusSpace,
    input  logic       autoVector,
    input  logic       ackEnd,
    output logic       cycleStart,
    output cycleKind_t cycleKind
);

    logic       busy;
    logic       startReq;
    logic       acceptTs;
    cycleKind_t kindSampled;
    cycleKind_t kindNext;

    //////////////////////////////////////////////////////////////////////
    // Classification
    //////////////////////////////////////////////////////////////////////

    // Priority, Agnus first since it overlaps other selects
    always_comb begin
        if (agnusSpace) begin
            kindSampled = kindAgnus;
        end else if (autoVector) begin
            kindSampled = kindAutoVec;
        end else if (romSel) begin
            kindSampled = kindRom;
        end else if (rtcSel) begin
            kindSampled = kindRtc;
        end else if (ciaSel) begin
            kindSampled = kindCia;
        end else begin
            kindSampled = kindOther;
        end
    end

    // Start pending counts as busy so a long tsN is taken once
    assign acceptTs = !tsN && !busy && !startReq;

    // Kind captured at the tsN edge
    always_ff @(posedge CLK40) begin
        if (acceptTs) begin
            kindNext <= kindSampled;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Start strobe and busy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            startReq   <= 1'b0;
            busy       <= 1'b0;
            cycleStart <= 1'b0;
            cycleKind  <= kindOther;
        end else begin
            startReq   <= acceptTs;
            // No termination for Agnus space
            cycleStart <= startReq && (kindNext != kindAgnus);
            if (startReq) begin
                cycleKind <= kindNext;
                busy      <= 1'b1;
            end else if (busy && (ackEnd || cycleKind == kindAgnus)) begin
                // Agnus cycles free decode one cycle after they are latched
                busy <= 1'b0;
            end
        end
    end

    // Start only from idle, busy is set on the same edge as the strobe
    assert property (@(posedge CLK40) disable iff (DELAYED_TACK_RST)
        cycleStart |-> !$past(busy))
        else $error("cycleStart issued while a cycle was in flight");

endmodule

// ==== rtl/termPkg.sv ====
// Termination-side types; counter width comes from the shared config header
`include "transferAck_cfg.svh"

package termPkg;

    // Shared delay counter of the execute stage
    typedef logic [`TERM_CNT_WIDTH-1:0] termCount_t;

    // Execute stage FSM
    typedef enum logic [2:0] {
        termIdle    = 3'd0,
        termWait    = 3'd1,
        termCiaHigh = 3'd2,
        termCiaLow  = 3'd3,
        termHold    = 3'd4
    } termState_t;

    // Result stage FSM, low pulse then driven high before release
    typedef enum logic [1:0] {
        ackIdle = 2'd0,
        ackLow  = 2'd1,
        ackHigh = 2'd2
    } ackState_t;

endpackage

// ==== rtl/busCyclePkg.sv ====
// Bus-side types only; the kind encoding is internal and never leaves the device

package busCyclePkg;

    //////////////////////////////////////////////////////////////////////
    // Cycle classification
    //////////////////////////////////////////////////////////////////////

    // Kind of the cycle in flight, set by the decode stage
    // Agnus space is recognized but never acknowledged here
    typedef enum logic [2:0] {
        // Boot ROM, cacheable
        kindRom     = 3'd0,
        // Real-time clock, long fixed wait
        kindRtc     = 3'd1,
        // Interrupt acknowledge, autovectored
        kindAutoVec = 3'd2,
        // CIA peripheral, ends on the CIA clock
        kindCia     = 3'd3,
        // Agnus owns the acknowledge
        kindAgnus   = 3'd4,
        // Anything else, external acknowledge or watchdog
        kindOther   = 3'd5
    } cycleKind_t;

    //////////////////////////////////////////////////////////////////////
    // Board jumpers
    //////////////////////////////////////////////////////////////////////

    // ROM speed jumper code, 0 fastest
    typedef logic [1:0] romDelay_t;

endpackage

// ==== rtl/transferAck_cfg.svh ====
// All counts are CLK40 cycles at 25 ns; TERM_CNT_WIDTH must hold the largest count below
`ifndef TRANSFERACK_CFG_SVH
`define TRANSFERACK_CFG_SVH

//////////////////////////////////////////////////////////////////////
// ROM termination delays
//////////////////////////////////////////////////////////////////////

// Cycles from cycle start to termination, one per jumper code
// Code 0 is the fastest ROM part, code 3 the slowest
`define ROM_DELAY_0 1
`define ROM_DELAY_1 2
`define ROM_DELAY_2 4
`define ROM_DELAY_3 8

//////////////////////////////////////////////////////////////////////
// Fixed waits
//////////////////////////////////////////////////////////////////////

// RTC part is slow, about 2 us per access
`define RTC_WAIT_CYCLES 80

// Unclaimed cycles end here, about 3.1 us
// Longer than the slowest CIA access
`define WATCHDOG_CYCLES 124

// Shared delay counter in the execute stage
`define TERM_CNT_WIDTH 7

`endif
